// File: Makefile
VERILATOR := verilator
TOP       := tb_blur_top
FILELIST  := compile.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+sim
src/blur_pkg.sv
src/blur_fsm.sv
src/row_addr_gen.sv
src/line_buffer.sv
src/gauss3_row_filter.sv
src/blur_top.sv
sim/tb_blur_top.sv

// File: sim/tb_gauss_ref.svh
`ifndef TB_GAUSS_REF_SVH
`define TB_GAUSS_REF_SVH

// image fills and the 3x3 reference blur, included inside tb_blur_top

task automatic fill_random();
  for (int r = 0; r < ROWS; r++) begin
    for (int c = 0; c < ROW_PIXELS; c++) begin
      img_mem[r][c] = pixel_t'($random(seed));        // fixed seed stream
    end
  end
endtask

task automatic fill_const(input pixel_t value);
  for (int r = 0; r < ROWS; r++) begin
    for (int c = 0; c < ROW_PIXELS; c++) begin
      img_mem[r][c] = value;
    end
  end
endtask

task automatic fill_pattern();
  for (int r = 0; r < ROWS; r++) begin
    for (int c = 0; c < ROW_PIXELS; c++) begin
      img_mem[r][c] = pixel_t'((r * 29) ^ (c * 13) ^ (r * c));  // row and column mixed
    end
  end
endtask

// stored pixel, zero anywhere outside the image
function automatic int img_pix(input int r, input int c);
  if ((r < 0) || (r >= ROWS) || (c < 0) || (c >= ROW_PIXELS)) begin
    return 0;
  end
  return int'(img_mem[r][c]);
endfunction

// expected output row r, weights 1-2-1 / 2-4-2 / 1-2-1 then divide by 16
function automatic row_t blur_row_ref(input int r);
  row_t out;
  int   acc;
  int   wt;
  out = '0;
  for (int c = 0; c < ROW_PIXELS; c++) begin
    acc = 0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        wt  = ((dy == 0) ? 2 : 1) * ((dx == 0) ? 2 : 1);  // outer product of 1-2-1
        acc = acc + wt * img_pix(r + dy, c + dx);
      end
    end
    out[c] = pixel_t'(acc >> 4);
  end
  return out;
endfunction

task automatic build_expected();
  for (int r = 0; r < ROWS; r++) begin
    next_rows[r] = blur_row_ref(r);                   // latched at the run's start
  end
endtask

`endif

// File: sim/tb_blur_top.sv
`timescale 1ns/100ps

module tb_blur_top import blur_pkg::*; ();

  localparam int ROWS            = 12;
  localparam int ADDR_W          = $clog2(ROWS + 1);
  localparam int CLK_PERIOD      = 40;                 // ns
  localparam int ROW_CYCLES      = 10;                 // one row per ten phases
  localparam int FIRST_WE        = 12;                 // first write after the start edge
  localparam int DONE_CYC        = ROW_CYCLES * ROWS + 2;
  localparam int NUM_IMAGES      = 3;
  localparam int WATCHDOG_CYCLES = NUM_IMAGES * 3 * (ROW_CYCLES * ROWS + 20);

  logic              clk;
  logic              rst_n;
  logic              start;
  row_t              img_dout;
  logic [ADDR_W-1:0] img_addr;
  logic [ADDR_W-1:0] blur_addr;
  row_t              blur_din;
  logic              blur_we;
  logic              done;

  row_t   img_mem     [ROWS];                          // image memory model
  row_t   blur_mem    [1 << ADDR_W];                   // blur memory model
  bit     row_written [1 << ADDR_W];                   // write seen in this run
  row_t   next_rows   [ROWS];                          // expected rows of the image being set up
  row_t   chk_rows    [ROWS];                          // expected rows of the run in flight
  integer seed;
  logic   start_is_run;                                // start pulse that opens a run
  logic   run_active;
  int     run_cyc;                                     // edges since the start edge
  logic   idle_after_reset;
  int     mem_bad_row = -1;                            // first wrong row or -1
  row_t   mem_exp;
  row_t   mem_act;
  int     err_value = 0;
  int     err_other = 0;
  logic   exp_we;
  logic   exp_done;
  int     exp_row;
  logic   addr_zero_due;
  logic   mem_check_due;

  `include "tb_gauss_ref.svh"

  blur_top #(
    .ROWS (ROWS)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .img_dout  (img_dout),
    .img_addr  (img_addr),
    .blur_addr (blur_addr),
    .blur_din  (blur_din),
    .blur_we   (blur_we),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // async image read with zeros past the bottom
  assign img_dout = (int'(img_addr) < ROWS) ? img_mem[img_addr] : '0;

  always @(posedge clk) begin
    if (start && start_is_run) begin
      for (int i = 0; i < (1 << ADDR_W); i++) begin
        row_written[i] <= 1'b0;                        // forget writes of the previous run
      end
    end else if (blur_we) begin
      blur_mem[blur_addr]    <= blur_din;
      row_written[blur_addr] <= 1'b1;
    end
  end

  // run position tracker
  always @(posedge clk) begin
    if (!rst_n) begin
      run_active       <= 1'b0;
      run_cyc          <= 0;
      idle_after_reset <= 1'b1;
    end else if (start && start_is_run) begin
      run_active       <= 1'b1;
      run_cyc          <= 1;                           // value seen at edge 1
      idle_after_reset <= 1'b0;
      for (int r = 0; r < ROWS; r++) begin
        chk_rows[r] <= next_rows[r];
      end
    end else if (run_active) begin
      run_cyc <= run_cyc + 1;
      if (run_cyc == DONE_CYC + 1) begin
        run_active <= 1'b0;                            // one edge past done
      end
    end
  end

  assign exp_we = run_active && (run_cyc >= FIRST_WE) && (run_cyc <= DONE_CYC)
                  && ((run_cyc - FIRST_WE) % ROW_CYCLES == 0);
  assign exp_done      = run_active && (run_cyc == DONE_CYC);
  assign exp_row       = (run_cyc - FIRST_WE) / ROW_CYCLES;
  assign addr_zero_due = idle_after_reset || (run_active && (run_cyc == DONE_CYC + 1));
  assign mem_check_due = run_active && (run_cyc == DONE_CYC + 1);

  // compare the filled blur memory while nothing moves
  always @(negedge clk) begin
    if (mem_check_due) begin
      mem_bad_row = -1;
      for (int r = ROWS - 1; r >= 0; r--) begin
        if (blur_mem[r] !== chk_rows[r]) begin
          mem_bad_row = r;                             // lowest wrong row wins
          mem_exp     = chk_rows[r];
          mem_act     = blur_mem[r];
        end
      end
    end
  end

  we_timing: assert property (@(posedge clk) disable iff (!rst_n) blur_we == exp_we)
    else begin
      err_value++;
      $display("ERR %0t blur_we expected %0b actual %0b",
               $time, $sampled(exp_we), $sampled(blur_we));
    end

  done_timing: assert property (@(posedge clk) disable iff (!rst_n) done == exp_done)
    else begin
      err_value++;
      $display("ERR %0t done expected %0b actual %0b",
               $time, $sampled(exp_done), $sampled(done));
    end

  addr_order: assert property (@(posedge clk) disable iff (!rst_n)
                               !exp_we || (int'(blur_addr) == exp_row))
    else begin
      err_value++;
      $display("ERR %0t blur_addr expected %0d actual %0d",
               $time, $sampled(exp_row), $sampled(blur_addr));
    end

  no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
                              !blur_we || !row_written[blur_addr])
    else begin
      err_other++;
      $display("blur row %0d written a second time in one run", $sampled(blur_addr));
    end

  // image counter stops at the bottom edge
  img_addr_sat: assert property (@(posedge clk) disable iff (!rst_n)
                                 int'(img_addr) <= ROWS)
    else begin
      err_value++;
      $display("ERR %0t img_addr expected at most %0d actual %0d",
               $time, ROWS, $sampled(img_addr));
    end

  img_addr_zero: assert property (@(posedge clk) disable iff (!rst_n)
                                  !addr_zero_due || (img_addr == '0))
    else begin
      err_value++;
      $display("ERR %0t img_addr expected 0 actual %0d", $time, $sampled(img_addr));
    end

  blur_addr_zero: assert property (@(posedge clk) disable iff (!rst_n)
                                   !addr_zero_due || (blur_addr == '0))
    else begin
      err_value++;
      $display("ERR %0t blur_addr expected 0 actual %0d", $time, $sampled(blur_addr));
    end

  mem_rows: assert property (@(posedge clk) disable iff (!rst_n)
                             !mem_check_due || (mem_bad_row < 0))
    else begin
      err_value++;
      $display("ERR %0t blur_mem[%0d] expected %h actual %h",
               $time, mem_bad_row, mem_exp, mem_act);
    end

  // one-cycle start pulse from a falling edge
  task automatic pulse_start(input logic opens_run);
    start        = 1'b1;
    start_is_run = opens_run;
    @(negedge clk);
    start        = 1'b0;
    start_is_run = 1'b0;
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (!done && (waited < DONE_CYC + 20)) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      err_other++;
      $display("done did not arrive within %0d cycles", DONE_CYC + 20);
    end
    @(negedge clk);                                    // step past the done cycle
  endtask

  initial begin
    start        = 1'b0;
    start_is_run = 1'b0;
    rst_n        = 1'b0;
    seed         = 32'h6b1d;
    for (int r = 0; r < ROWS; r++) begin
      img_mem[r]   = '0;
      next_rows[r] = '0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);                         // idle while reset values are checked

    fill_random();
    build_expected();
    pulse_start(1'b1);
    repeat (30) @(negedge clk);
    pulse_start(1'b0);                                 // lands mid row and must be ignored
    wait_for_done();

    fill_const(8'hff);
    build_expected();
    pulse_start(1'b1);                                 // right after the first run
    pulse_start(1'b0);                                 // seen in st_ready
    wait_for_done();

    fill_pattern();
    build_expected();
    pulse_start(1'b1);
    wait_for_done();
    repeat (3) @(negedge clk);                         // last memory compare

    $display("error counts: %0d value, %0d other", err_value, err_other);
    if ((err_value + err_other) == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the runs did not finish", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: src/blur_fsm.sv
`timescale 1ns/100ps

module blur_fsm import blur_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,     // one-cycle request, only seen in idle
  input  logic       last_row,  // row being filtered is the bottom one
  output blur_ctrl_t ctrl
);

  localparam seg_idx_t LAST_SEG = seg_idx_t'(NUM_SEGS - 1);

  blur_state_e state;
  blur_state_e state_nxt;
  seg_idx_t    phase;
  seg_idx_t    phase_nxt;
  logic        seg_wrap;        // phase 9 of a row

  assign seg_wrap = (state == st_blur) && (phase == LAST_SEG);

  always_comb begin
    state_nxt = state;          // hold by default
    phase_nxt = '0;             // phase only counts inside st_blur
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_ready;
        end
      end
      st_ready: begin
        state_nxt = st_blur;    // always one cycle, enter at phase 0
      end
      st_blur: begin
        if (seg_wrap) begin
          if (last_row) begin
            state_nxt = st_idle;  // bottom row finished
          end
        end else begin
          phase_nxt = phase + seg_idx_t'(1);
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      phase <= '0;
    end else begin
      state <= state_nxt;
      phase <= phase_nxt;
    end
  end

  // strobe decode, all combinational from state and phase
  always_comb begin
    ctrl            = '0;
    ctrl.load_first = (state == st_idle) && start;
    ctrl.shift      = (state == st_ready) || seg_wrap;  // row 1 fetch, then each row end
    ctrl.row_end    = seg_wrap;
    ctrl.seg_idx    = phase;
  end

endmodule

// File: src/blur_pkg.sv
package blur_pkg;

  // pixel and row geometry
  parameter int PIX_W      = 8;                      // grayscale depth
  parameter int SEG_PIXELS = 4;                      // pixels filtered per phase
  parameter int NUM_SEGS   = 10;                     // phases per row cycle
  parameter int ROW_PIXELS = SEG_PIXELS * NUM_SEGS;  // 40 pixels per memory word

  typedef logic [PIX_W-1:0] pixel_t;

  // pixel 0 in the low bits
  typedef pixel_t [ROW_PIXELS-1:0] row_t;

  typedef logic [3:0] seg_idx_t;                     // phase 0..NUM_SEGS-1

  // three consecutive image rows around the row being filtered
  typedef struct packed {
    row_t top;                                       // row r-1
    row_t mid;                                       // row r, the one written out
    row_t bot;                                       // row r+1
  } line_window_t;

  typedef enum logic [1:0] {
    st_idle,                                         // waiting for start
    st_ready,                                        // one cycle, second row fetch
    st_blur                                          // ten-phase row cycle
  } blur_state_e;

  // control bundle from the FSM, 7 bits
  typedef struct packed {
    logic     load_first;                            // first row load into bot
    logic     shift;                                 // window moves up one row
    logic     row_end;                               // last phase of a row
    seg_idx_t seg_idx;                               // current phase
  } blur_ctrl_t;

endpackage

// File: src/blur_top.sv
`timescale 1ns/100ps

module blur_top import blur_pkg::*; #(
  parameter int ROWS = 12                               // image height in rows
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  row_t                      img_dout,
  output logic [$clog2(ROWS+1)-1:0] img_addr,
  output logic [$clog2(ROWS+1)-1:0] blur_addr,
  output row_t                      blur_din,
  output logic                      blur_we,
  output logic                      done
);

  blur_ctrl_t   ctrl;                                   // row-cycle strobes and phase
  logic         last_row;
  logic         fill_zero;
  line_window_t win;                                    // rows r-1, r, r+1

  blur_fsm i_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .last_row (last_row),
    .ctrl     (ctrl)
  );

  row_addr_gen #(
    .ROWS (ROWS)
  ) i_addr (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .img_addr  (img_addr),
    .blur_addr (blur_addr),
    .fill_zero (fill_zero),
    .last_row  (last_row),
    .blur_we   (blur_we),
    .done      (done)
  );

  line_buffer i_lbuf (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .img_dout  (img_dout),
    .fill_zero (fill_zero),
    .win       (win)
  );

  gauss3_row_filter i_filt (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .win      (win),
    .blur_din (blur_din)
  );

endmodule

// File: src/gauss3_row_filter.sv
`timescale 1ns/100ps

module gauss3_row_filter import blur_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  blur_ctrl_t   ctrl,
  input  line_window_t win,
  output row_t         blur_din       // assembled output row
);

  localparam int HSUM_W = PIX_W + 2;  // 1-2-1 of one row, max 1020
  localparam int SUM_W  = PIX_W + 4;  // full 3x3 weight 16, max 4080

  // pixel with zero padding left of 0 and right of the last column
  function automatic pixel_t pix_at(input row_t r, input int i);
    pixel_t p;
    p = '0;
    if ((i >= 0) && (i < ROW_PIXELS)) begin
      p = r[i];
    end
    return p;
  endfunction

  // horizontal 1-2-1 around column i
  function automatic logic [HSUM_W-1:0] hsum(input row_t r, input int i);
    logic [HSUM_W-1:0] left;
    logic [HSUM_W-1:0] centre;
    logic [HSUM_W-1:0] right;
    left   = HSUM_W'(pix_at(r, i - 1));
    centre = HSUM_W'(pix_at(r, i));
    right  = HSUM_W'(pix_at(r, i + 1));
    return left + (centre << 1) + right;
  endfunction

  logic [SUM_W-1:0] sum [SEG_PIXELS];  // weighted 3x3 sums of this segment
  pixel_t           res [SEG_PIXELS];  // scaled back to pixel range
  int               base;              // first column of the segment

  always_comb begin
    base = int'(ctrl.seg_idx) * SEG_PIXELS;
    for (int k = 0; k < SEG_PIXELS; k++) begin
      sum[k] = SUM_W'(hsum(win.top, base + k))
             + (SUM_W'(hsum(win.mid, base + k)) << 1)  // middle row weighs twice
             + SUM_W'(hsum(win.bot, base + k));
      res[k] = pixel_t'(sum[k] >> 4);                 // divide by kernel weight 16
    end
  end

  // one segment stored per phase, others hold
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_din <= '0;
    end else begin
      for (int k = 0; k < SEG_PIXELS; k++) begin
        blur_din[base + k] <= res[k];
      end
    end
  end

endmodule

// File: src/line_buffer.sv
`timescale 1ns/100ps

module line_buffer import blur_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  blur_ctrl_t   ctrl,
  input  row_t         img_dout,   // async read of the image memory
  input  logic         fill_zero,  // past the bottom edge
  output line_window_t win
);

  row_t new_row;                   // row entering at the bottom

  assign new_row = fill_zero ? '0 : img_dout;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win <= '0;
    end else if (ctrl.load_first) begin
      win.top <= '0;               // rows above the image
      win.mid <= '0;
      win.bot <= img_dout;         // row 0
    end else if (ctrl.shift) begin
      win.top <= win.mid;
      win.mid <= win.bot;
      win.bot <= new_row;
    end
  end

endmodule

// File: src/row_addr_gen.sv
`timescale 1ns/100ps

module row_addr_gen import blur_pkg::*; #(
  parameter int ROWS = 12                               // image height
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  blur_ctrl_t                ctrl,
  output logic [$clog2(ROWS+1)-1:0] img_addr,           // image memory row
  output logic [$clog2(ROWS+1)-1:0] blur_addr,          // blur memory row
  output logic                      fill_zero,          // below the image, pad with zeros
  output logic                      last_row,
  output logic                      blur_we,
  output logic                      done
);

  localparam int                ADDR_W    = $clog2(ROWS + 1);
  localparam logic [ADDR_W-1:0] IMG_END   = ADDR_W'(ROWS);      // saturation point
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(ROWS - 1);

  logic fetch;                                          // line buffer takes img_dout

  assign fetch     = ctrl.load_first | ctrl.shift;
  assign fill_zero = (img_addr == IMG_END);
  assign last_row  = (blur_addr == LAST_ADDR);          // blur_addr tracks the row in flight

  // image row counter, stops at ROWS
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_addr <= '0;
    end else if (done) begin
      img_addr <= '0;                                   // ready for the next run
    end else if (fetch && (img_addr < IMG_END)) begin
      img_addr <= img_addr + ADDR_W'(1);
    end
  end

  // blur row counter, steps after each write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_addr <= '0;
    end else if (done) begin
      blur_addr <= '0;                                  // final write lands first
    end else if (blur_we) begin
      blur_addr <= blur_addr + ADDR_W'(1);
    end
  end

  // write strobe one cycle after the row's last phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
      done    <= 1'b0;
    end else begin
      blur_we <= ctrl.row_end;
      done    <= ctrl.row_end & last_row;               // rides with the final blur_we
    end
  end

endmodule
